/* design/csb_reg_port.sv */
`timescale 1ns/1ps
`default_nettype none

module csb_reg_port
  import pdp_rdma_reg_pkg::*;
(
  input  wire logic              nvdla_core_clk,
  input  wire logic              nvdla_core_rstn,
  input  wire logic              csb_req_valid,
  input  wire csb_req_t          csb_req,
  input  wire logic [data_w-1:0] rd_data,         // merged group read data
  output logic                   csb_req_ready,
  output reg_bus_t               reg_bus,
  output logic                   csb_resp_valid,
  output csb_resp_t              csb_resp
);

  csb_req_t  req_q;      // captured request
  logic      req_pvld;   // request valid, one cycle late
  logic      reg_rd_en;
  logic      reg_wr_en;
  csb_resp_t rresp;      // read response word
  csb_resp_t wresp;      // write response word

  assign csb_req_ready = 1'b1;  // never stalls

  //////////////////////////////////////////////////
  // request capture
  //////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_pvld <= 1'b0;
    end else begin
      req_pvld <= csb_req_valid;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (csb_req_valid) begin
      req_q <= csb_req;  // payload only
    end
  end

  // csb address is in words, register offsets in bytes
  assign reg_bus.offset  = {req_q.addr[reg_offset_w-3:0], 2'b00};
  assign reg_bus.wr_data = req_q.wdat;
  assign reg_bus.wr_en   = reg_wr_en;

  assign reg_wr_en = req_pvld & req_q.write;
  assign reg_rd_en = req_pvld & ~req_q.write;

  //////////////////////////////////////////////////
  // responses
  //////////////////////////////////////////////////
  assign rresp.is_write = op_read;
  assign rresp.error    = 1'b0;
  assign rresp.rdat     = rd_data;    // registers before this edge's write

  assign wresp.is_write = op_write;
  assign wresp.error    = 1'b0;
  assign wresp.rdat     = '0;

  always_ff @(posedge nvdla_core_clk) begin
    if (reg_rd_en) begin
      csb_resp <= rresp;
    end else if (reg_wr_en & req_q.nposted) begin
      csb_resp <= wresp;
    end
  end

  // posted writes stay silent
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      csb_resp_valid <= 1'b0;
    end else begin
      csb_resp_valid <= reg_rd_en | (reg_wr_en & req_q.nposted);
    end
  end

  // a valid response never carries unknown bits
  ap_resp_known : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    csb_resp_valid |-> !$isunknown(csb_resp)
  ) else $error("csb response word has unknown bits");

endmodule

`default_nettype wire

/* design/launch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module launch_ctrl
  import pdp_rdma_reg_pkg::*;
#(
  parameter int OP_EN_DELAY = 3  // op_en to datapath latency, 2 or more
) (
  input  wire logic              nvdla_core_clk,
  input  wire logic              nvdla_core_rstn,
  input  wire logic              dp_done,      // layer finished
  input  wire logic              trigger_d0,
  input  wire logic              trigger_d1,
  input  wire logic [data_w-1:0] wr_data,      // bit 0 is the op_en value
  input  wire rdma_cfg_t         cfg_d0,
  input  wire rdma_cfg_t         cfg_d1,
  output logic [1:0]             op_en,
  output logic                   consumer,
  output group_status_e          status_0,
  output group_status_e          status_1,
  output rdma_cfg_t              dp_cfg,
  output logic                   dp_op_en,
  output logic                   slcg_op_en
);

  logic [1:0]             trigger;
  logic [1:0]             op_en_w;
  logic                   op_en_ori;  // op_en of the consumed group
  logic [OP_EN_DELAY-1:0] op_en_sr;
  logic [2:0]             slcg_sr;    // clock gate opens 3 cycles late

  assign trigger = {trigger_d1, trigger_d0};

  //////////////////////////////////////////////////
  // consumer pointer
  //////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      consumer <= 1'b0;
    end else if (dp_done) begin
      consumer <= ~consumer;  // hand over to the other copy
    end
  end

  //////////////////////////////////////////////////
  // per group op_en
  //////////////////////////////////////////////////
  always_comb begin
    for (int g = 0; g < 2; g++) begin
      if (~op_en[g] & trigger[g]) begin
        op_en_w[g] = wr_data[0];
      end else if (dp_done && (consumer == g[0])) begin
        op_en_w[g] = 1'b0;  // consumed group released
      end else begin
        op_en_w[g] = op_en[g];
      end
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en <= 2'b00;
    end else begin
      op_en <= op_en_w;
    end
  end

  // status, group 0 runs when consumer is 0
  assign status_0 = !op_en[0] ? st_idle : (!consumer ? st_running : st_pending);
  assign status_1 = !op_en[1] ? st_idle : (consumer ? st_running : st_pending);

  //////////////////////////////////////////////////
  // datapath launch
  //////////////////////////////////////////////////
  assign op_en_ori = consumer ? op_en[1] : op_en[0];

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_sr <= '0;
      slcg_sr  <= 3'b000;
    end else begin
      op_en_sr <= dp_done ? '0 : {op_en_sr[OP_EN_DELAY-2:0], op_en_ori};  // restart on done
      slcg_sr  <= {slcg_sr[1:0], op_en_ori};
    end
  end

  assign dp_op_en   = op_en_sr[OP_EN_DELAY-1];
  assign slcg_op_en = slcg_sr[2];
  assign dp_cfg     = consumer ? cfg_d1 : cfg_d0;  // active copy

  ap_done_known : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !$isunknown(dp_done)
  ) else $error("dp_done is X");

endmodule

`default_nettype wire

/* design/pdp_rdma_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module pdp_rdma_reg
  import pdp_rdma_reg_pkg::*;
#(
  parameter int OP_EN_DELAY = 3
) (
  input  wire logic              nvdla_core_clk,
  input  wire logic              nvdla_core_rstn,
  input  wire logic              csb_req_valid,
  input  wire csb_req_t          csb_req,
  input  wire logic              dp_done,
  input  wire logic [data_w-1:0] perf_read_stall_d0,
  input  wire logic [data_w-1:0] perf_read_stall_d1,
  output logic                   csb_req_ready,
  output logic                   csb_resp_valid,
  output csb_resp_t              csb_resp,
  output rdma_cfg_t              dp_cfg,
  output logic                   dp_op_en,
  output logic                   slcg_op_en
);

  reg_bus_t          reg_bus;     // from the csb port
  reg_bus_t          s_bus;
  reg_bus_t          d0_bus;
  reg_bus_t          d1_bus;
  logic [data_w-1:0] rd_data;
  logic [data_w-1:0] s_rd_data;
  logic [data_w-1:0] d0_rd_data;
  logic [data_w-1:0] d1_rd_data;
  logic              producer;
  logic              consumer;
  logic [1:0]        op_en;
  group_status_e     status_0;
  group_status_e     status_1;
  rdma_cfg_t         cfg_d0;
  rdma_cfg_t         cfg_d1;
  logic              trigger_d0;
  logic              trigger_d1;

  csb_reg_port u_port (
    .nvdla_core_clk, .nvdla_core_rstn, .csb_req_valid, .csb_req,
    .rd_data, .csb_req_ready, .reg_bus, .csb_resp_valid, .csb_resp
  );

  reg_group_select u_select (
    .nvdla_core_clk, .nvdla_core_rstn, .reg_bus, .producer, .op_en,
    .s_rd_data, .d0_rd_data, .d1_rd_data, .s_bus, .d0_bus, .d1_bus, .rd_data
  );

  reg_single_group u_single (
    .nvdla_core_clk, .nvdla_core_rstn, .bus(s_bus), .consumer,
    .status_0, .status_1, .producer, .rd_data(s_rd_data)
  );

  // two copies of the layer configuration
  reg_dual_group u_dual_d0 (
    .nvdla_core_clk, .nvdla_core_rstn, .bus(d0_bus), .op_en(op_en[0]),
    .perf_read_stall(perf_read_stall_d0), .cfg(cfg_d0),
    .op_en_trigger(trigger_d0), .rd_data(d0_rd_data)
  );

  reg_dual_group u_dual_d1 (
    .nvdla_core_clk, .nvdla_core_rstn, .bus(d1_bus), .op_en(op_en[1]),
    .perf_read_stall(perf_read_stall_d1), .cfg(cfg_d1),
    .op_en_trigger(trigger_d1), .rd_data(d1_rd_data)
  );

  launch_ctrl #(.OP_EN_DELAY(OP_EN_DELAY)) u_launch (
    .nvdla_core_clk, .nvdla_core_rstn, .dp_done, .trigger_d0, .trigger_d1,
    .wr_data(reg_bus.wr_data), .cfg_d0, .cfg_d1, .op_en, .consumer,
    .status_0, .status_1, .dp_cfg, .dp_op_en, .slcg_op_en
  );

endmodule

`default_nettype wire

/* design/pdp_rdma_reg_pkg.sv */
`default_nettype none

package pdp_rdma_reg_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////
  localparam int unsigned reg_offset_w = 12;  // 4 KB per subunit
  localparam int unsigned data_w       = 32;
  localparam int unsigned cube_w       = 13;  // cube width/height/channel

  //////////////////////////////////////////////////
  // register map, byte offsets
  //////////////////////////////////////////////////
  // single group
  localparam logic [reg_offset_w-1:0] off_s_status       = 12'h000;
  localparam logic [reg_offset_w-1:0] off_s_pointer      = 12'h004;
  // dual groups
  localparam logic [reg_offset_w-1:0] off_d_op_enable    = 12'h008;
  localparam logic [reg_offset_w-1:0] off_d_cube_width   = 12'h00c;
  localparam logic [reg_offset_w-1:0] off_d_cube_height  = 12'h010;
  localparam logic [reg_offset_w-1:0] off_d_cube_channel = 12'h014;
  localparam logic [reg_offset_w-1:0] off_d_base_low     = 12'h018;
  localparam logic [reg_offset_w-1:0] off_d_base_high    = 12'h01c;
  localparam logic [reg_offset_w-1:0] off_d_line_stride  = 12'h020;
  localparam logic [reg_offset_w-1:0] off_d_surf_stride  = 12'h024;
  localparam logic [reg_offset_w-1:0] off_d_perf_stall   = 12'h028;  // read only

  // everything from here up belongs to a dual group
  localparam logic [reg_offset_w-1:0] off_d_first = off_d_op_enable;

  //////////////////////////////////////////////////
  // enums
  //////////////////////////////////////////////////
  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_pending = 2'd1,  // enabled, waiting for the other group
    st_running = 2'd2   // enabled and owned by the datapath
  } group_status_e;

  // response kind, bit 33 of the response word
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } csb_op_e;

  //////////////////////////////////////////////////
  // structs
  //////////////////////////////////////////////////
  // csb request, 63 bits; msb first so addr lands on [21:0]
  typedef struct packed {
    logic [1:0]        level;    // [62:61]
    logic [3:0]        wrbe;     // [60:57]
    logic              srcpriv;  // [56]
    logic              nposted;  // [55]
    logic              write;    // [54]
    logic [data_w-1:0] wdat;     // [53:22]
    logic [21:0]       addr;     // word address
  } csb_req_t;

  // csb response, 34 bits
  typedef struct packed {
    csb_op_e           is_write;  // [33]
    logic              error;     // [32]
    logic [data_w-1:0] rdat;      // [31:0]
  } csb_resp_t;

  // shared register write bus
  typedef struct packed {
    logic [reg_offset_w-1:0] offset;
    logic [data_w-1:0]       wr_data;
    logic                    wr_en;
  } reg_bus_t;

  // one copy of the layer configuration
  typedef struct packed {
    logic [cube_w-1:0] cube_width;
    logic [cube_w-1:0] cube_height;
    logic [cube_w-1:0] cube_channel;
    logic [data_w-1:0] base_low;
    logic [data_w-1:0] base_high;
    logic [data_w-1:0] line_stride;
    logic [data_w-1:0] surf_stride;
  } rdma_cfg_t;

endpackage

`default_nettype wire

/* design/reg_dual_group.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_dual_group
  import pdp_rdma_reg_pkg::*;
(
  input  wire logic              nvdla_core_clk,
  input  wire logic              nvdla_core_rstn,
  input  wire reg_bus_t          bus,              // wr_en already granted
  input  wire logic              op_en,            // this group's enable, for readback
  input  wire logic [data_w-1:0] perf_read_stall,
  output rdma_cfg_t              cfg,
  output logic                   op_en_trigger,    // one-shot on op_enable write
  output logic [data_w-1:0]      rd_data
);

  localparam int unsigned pad_w = data_w - cube_w;  // zero fill for cube fields

  // op_en itself lives in launch_ctrl, here only the strobe
  assign op_en_trigger = bus.wr_en && (bus.offset == off_d_op_enable);

  //////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cfg <= '0;
    end else if (bus.wr_en) begin
      case (bus.offset)
        off_d_cube_width:   cfg.cube_width   <= bus.wr_data[cube_w-1:0];  // upper bits dropped
        off_d_cube_height:  cfg.cube_height  <= bus.wr_data[cube_w-1:0];
        off_d_cube_channel: cfg.cube_channel <= bus.wr_data[cube_w-1:0];
        off_d_base_low:     cfg.base_low     <= bus.wr_data;
        off_d_base_high:    cfg.base_high    <= bus.wr_data;
        off_d_line_stride:  cfg.line_stride  <= bus.wr_data;
        off_d_surf_stride:  cfg.surf_stride  <= bus.wr_data;
        default: begin
          // op_enable, perf and holes write nothing here
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////
  always_comb begin
    case (bus.offset)
      off_d_op_enable: begin
        rd_data = {{(data_w-1){1'b0}}, op_en};
      end
      off_d_cube_width: begin
        rd_data = {{pad_w{1'b0}}, cfg.cube_width};
      end
      off_d_cube_height: begin
        rd_data = {{pad_w{1'b0}}, cfg.cube_height};
      end
      off_d_cube_channel: begin
        rd_data = {{pad_w{1'b0}}, cfg.cube_channel};
      end
      off_d_base_low:    rd_data = cfg.base_low;
      off_d_base_high:   rd_data = cfg.base_high;
      off_d_line_stride: rd_data = cfg.line_stride;
      off_d_surf_stride: rd_data = cfg.surf_stride;
      off_d_perf_stall:  rd_data = perf_read_stall;  // straight from the datapath
      default: begin
        rd_data = '0;  // unmapped
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/reg_group_select.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_group_select
  import pdp_rdma_reg_pkg::*;
(
  input  wire logic              nvdla_core_clk,
  input  wire logic              nvdla_core_rstn,
  input  wire reg_bus_t          reg_bus,
  input  wire logic              producer,    // group software is programming
  input  wire logic [1:0]        op_en,       // per group lock
  input  wire logic [data_w-1:0] s_rd_data,
  input  wire logic [data_w-1:0] d0_rd_data,
  input  wire logic [data_w-1:0] d1_rd_data,
  output reg_bus_t               s_bus,
  output reg_bus_t               d0_bus,
  output reg_bus_t               d1_bus,
  output logic [data_w-1:0]      rd_data
);

  logic select_s;
  logic select_d0;
  logic select_d1;

  // low offsets are the single group, the rest is the producer's copy
  assign select_s  = (reg_bus.offset < off_d_first);
  assign select_d0 = ~select_s & ~producer;
  assign select_d1 = ~select_s & producer;

  //////////////////////////////////////////////////
  // write grant
  //////////////////////////////////////////////////
  always_comb begin
    s_bus        = reg_bus;
    d0_bus       = reg_bus;
    d1_bus       = reg_bus;
    s_bus.wr_en  = reg_bus.wr_en & select_s;
    d0_bus.wr_en = reg_bus.wr_en & select_d0 & ~op_en[0];  // locked while enabled
    d1_bus.wr_en = reg_bus.wr_en & select_d1 & ~op_en[1];
  end

  // read merge
  assign rd_data = ({data_w{select_s}}  & s_rd_data)  |
                   ({data_w{select_d0}} & d0_rd_data) |
                   ({data_w{select_d1}} & d1_rd_data);

  // software must not reprogram a group the datapath still owns
  ap_no_locked_write : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (reg_bus.wr_en && !select_s) |-> !op_en[producer]
  ) else $error("write to dual group %0d while op_en is set", producer);

endmodule

`default_nettype wire

/* design/reg_single_group.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_single_group
  import pdp_rdma_reg_pkg::*;
(
  input  wire logic          nvdla_core_clk,
  input  wire logic          nvdla_core_rstn,
  input  wire reg_bus_t      bus,
  input  wire logic          consumer,   // group the datapath runs
  input  wire group_status_e status_0,
  input  wire group_status_e status_1,
  output logic               producer,   // group software writes
  output logic [data_w-1:0]  rd_data
);

  logic ptr_wr;

  //////////////////////////////////////////////////
  // producer pointer
  //////////////////////////////////////////////////
  assign ptr_wr = bus.wr_en && (bus.offset == off_s_pointer);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      producer <= 1'b0;
    end else if (ptr_wr) begin
      producer <= bus.wr_data[0];  // only bit 0 is writable
    end
  end

  //////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////
  always_comb begin
    case (bus.offset)
      off_s_status: begin
        // group 0 low half, group 1 high half
        rd_data = {14'b0, status_1, 14'b0, status_0};
      end
      off_s_pointer: begin
        rd_data = {15'b0, consumer, 15'b0, producer};
      end
      default: begin
        rd_data = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* pdp_rdma_reg.f */
+incdir+test
design/pdp_rdma_reg_pkg.sv
design/csb_reg_port.sv
design/reg_group_select.sv
design/reg_single_group.sv
design/reg_dual_group.sv
design/launch_ctrl.sv
design/pdp_rdma_reg.sv
test/tb_pdp_rdma_reg.sv

/* run_sim.sh */
#!/bin/sh
# build and run the register block testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_pdp_rdma_reg -f pdp_rdma_reg.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi
exit 0

/* test/tb_reg_model.svh */
`ifndef TB_REG_MODEL_SVH
`define TB_REG_MODEL_SVH

//////////////////////////////////////////////////
// shadow model of the register block
//////////////////////////////////////////////////
logic [31:0] lcg_state = 32'he4f8_ad9b;
logic        producer_m;   // group software programs
logic        consumer_m;   // group the datapath runs
logic [1:0]  op_en_m;
rdma_cfg_t   cfg_m [2];
logic [31:0] stall_m [2];  // values driven on the stall inputs

// lcg, numerical recipes constants
function automatic logic [31:0] rand_word();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

function automatic group_status_e status_of(input logic g);
  if (!op_en_m[g]) begin
    return st_idle;
  end
  return (consumer_m == g) ? st_running : st_pending;  // enabled but waiting
endfunction

function automatic void model_write(input logic [11:0] offset, input logic [31:0] data);
  rdma_cfg_t c;
  logic      p;
  p = producer_m;  // copy addressed by this write
  c = cfg_m[p];
  case (offset)
    off_s_pointer:      producer_m = data[0];
    off_d_op_enable:    op_en_m[producer_m] = data[0];  // only ever written while clear
    off_d_cube_width:   c.cube_width = data[cube_w-1:0];   // truncated
    off_d_cube_height:  c.cube_height = data[cube_w-1:0];
    off_d_cube_channel: c.cube_channel = data[cube_w-1:0];
    off_d_base_low:     c.base_low = data;
    off_d_base_high:    c.base_high = data;
    off_d_line_stride:  c.line_stride = data;
    off_d_surf_stride:  c.surf_stride = data;
    default: begin
      // status and perf are read only
    end
  endcase
  cfg_m[p] = c;
endfunction

// expected read word for an offset, dual offsets from the producer's copy
function automatic logic [31:0] exp_read(input logic [11:0] offset);
  rdma_cfg_t   c;
  logic [31:0] v;
  c = cfg_m[producer_m];
  case (offset)
    off_s_status:       v = {14'd0, status_of(1'b1), 14'd0, status_of(1'b0)};
    off_s_pointer:      v = {15'd0, consumer_m, 15'd0, producer_m};
    off_d_op_enable:    v = {31'd0, op_en_m[producer_m]};
    off_d_cube_width:   v = {19'd0, c.cube_width};
    off_d_cube_height:  v = {19'd0, c.cube_height};
    off_d_cube_channel: v = {19'd0, c.cube_channel};
    off_d_base_low:     v = c.base_low;
    off_d_base_high:    v = c.base_high;
    off_d_line_stride:  v = c.line_stride;
    off_d_surf_stride:  v = c.surf_stride;
    off_d_perf_stall:   v = stall_m[producer_m];
    default:            v = 32'd0;
  endcase
  return v;
endfunction

//////////////////////////////////////////////////
// csb request tasks
//////////////////////////////////////////////////
// one request cycle, returns on the edge that samples it
task automatic send_req(input logic wr, input logic np, input logic [11:0] offset,
                        input logic [31:0] wdat);
  csb_req_t r;
  r         = '0;
  r.addr    = {12'd0, offset[11:2]};  // word address
  r.wdat    = wdat;
  r.write   = wr;
  r.nposted = np;
  r.wrbe    = 4'hf;
  @(posedge nvdla_core_clk);
  csb_req_valid <= 1'b1;
  csb_req       <= r;
  @(posedge nvdla_core_clk);
  csb_req_valid <= 1'b0;
endtask

task automatic wait_resp(output logic got, output csb_resp_t r);
  int n;
  got = 1'b0;
  r   = '0;
  for (n = 0; n < 8 && !got; n++) begin
    @(negedge nvdla_core_clk);
    if (csb_resp_valid) begin
      got = 1'b1;
      r   = csb_resp;
    end
  end
  if (!got) begin
    timeouts++;
    $display("no csb response within 8 cycles, time %0t", $time);
  end else begin
    check_value("response latency in edges", n, 32'd2);  // sampling edge counts as 1
    check_bit("response error flag", r.error, 1'b0);
  end
endtask

task automatic reg_write(input logic np, input logic [11:0] offset, input logic [31:0] wdat);
  logic      got;
  csb_resp_t r;
  int        n;
  send_req(1'b1, np, offset, wdat);
  model_write(offset, wdat);
  if (np) begin
    wait_resp(got, r);
    if (got) begin
      check_bit("write response kind", r.is_write, 1'b1);
      check_value("write response rdat", r.rdat, 32'd0);
      @(negedge nvdla_core_clk);
      check_bit("write response single cycle", csb_resp_valid, 1'b0);
    end
  end else begin
    for (n = 0; n < 4; n++) begin  // posted, window must stay quiet
      @(negedge nvdla_core_clk);
      check_bit("posted write response", csb_resp_valid, 1'b0);
    end
  end
endtask

task automatic read_and_check(input logic [11:0] offset, input string what);
  logic      got;
  csb_resp_t r;
  send_req(1'b0, 1'b0, offset, rand_word());
  wait_resp(got, r);
  if (got) begin
    check_bit("read response kind", r.is_write, 1'b0);
    check_value(what, r.rdat, exp_read(offset));
  end
endtask

`endif

/* test/tb_pdp_rdma_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pdp_rdma_reg
  import pdp_rdma_reg_pkg::*;
;

  logic              nvdla_core_clk;
  logic              nvdla_core_rstn;
  logic              csb_req_valid;
  csb_req_t          csb_req;
  logic              dp_done;
  logic [data_w-1:0] perf_read_stall_d0;
  logic [data_w-1:0] perf_read_stall_d1;
  logic              csb_req_ready;
  logic              csb_resp_valid;
  csb_resp_t         csb_resp;
  rdma_cfg_t         dp_cfg;
  logic              dp_op_en;
  logic              slcg_op_en;

  int checks = 0;
  int errors = 0;
  int timeouts = 0;

  //////////////////////////////////////////////////
  // checks and run end
  //////////////////////////////////////////////////
  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t: %s got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t: %s got %0b expected %0b", $time, what, got, exp);
    end
  endtask

  task automatic check_cfg(input string what, input rdma_cfg_t got, input rdma_cfg_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  `include "tb_reg_model.svh"

  pdp_rdma_reg #(.OP_EN_DELAY(3)) DUT (
    .nvdla_core_clk, .nvdla_core_rstn, .csb_req_valid, .csb_req, .dp_done,
    .perf_read_stall_d0, .perf_read_stall_d1, .csb_req_ready, .csb_resp_valid,
    .csb_resp, .dp_cfg, .dp_op_en, .slcg_op_en
  );

  initial begin : clock_gen
    nvdla_core_clk = 1'b0;
    forever #20 nvdla_core_clk = ~nvdla_core_clk;  // 40 ns
  end

  //////////////////////////////////////////////////
  // sequence steps
  //////////////////////////////////////////////////
  task automatic drive_stall();
    stall_m[0] = rand_word();
    stall_m[1] = rand_word();
    @(posedge nvdla_core_clk);
    perf_read_stall_d0 <= stall_m[0];
    perf_read_stall_d1 <= stall_m[1];
  endtask

  // random config writes to one unlocked group, then full readback
  task automatic program_group(input logic g);
    logic [31:0] idx;
    int          k;
    reg_write(rand_word() % 32'd2 == 32'd1, off_s_pointer, {rand_word() & 32'hffff_fffe} | g);
    for (k = 0; k < 6; k++) begin
      idx = rand_word() % 32'd7;
      reg_write(rand_word() % 32'd2 == 32'd1, off_d_cube_width + 12'(idx * 4), rand_word());
    end
    for (k = 0; k < 7; k++) begin
      read_and_check(off_d_cube_width + 12'(k * 4), "config readback");
    end
    read_and_check(off_d_op_enable, "op_enable readback");
    read_and_check(off_d_perf_stall, "read stall count");
  endtask

  // enable the consumed group and time the launch pulse
  task automatic launch_group(input logic g);
    int k;
    if (producer_m != g) begin
      reg_write(1'b1, off_s_pointer, {31'd0, g});
    end
    send_req(1'b1, 1'b0, off_d_op_enable, rand_word() | 32'd1);
    model_write(off_d_op_enable, 32'd1);
    for (k = 1; k <= 5; k++) begin
      @(negedge nvdla_core_clk);  // after edge k-1 past the sampling edge
      check_bit("dp_op_en launch timing", dp_op_en, k == 5);
      check_bit("slcg_op_en launch timing", slcg_op_en, k == 5);
    end
  endtask

  task automatic wait_launch();
    int   n;
    logic seen;
    seen = 1'b0;
    for (n = 0; n < 10 && !seen; n++) begin
      @(negedge nvdla_core_clk);
      seen = dp_op_en;
    end
    if (!seen) begin
      timeouts++;
      $display("dp_op_en never rose for the pending group, time %0t", $time);
    end
    check_bit("slcg_op_en with pending launch", slcg_op_en, 1'b1);
  endtask

  task automatic finish_layer();
    logic c;
    c = consumer_m;
    @(posedge nvdla_core_clk);
    dp_done <= 1'b1;
    @(posedge nvdla_core_clk);  // this edge samples done
    dp_done <= 1'b0;
    consumer_m = ~c;
    op_en_m[c] = 1'b0;
    @(negedge nvdla_core_clk);
    check_bit("dp_op_en after done", dp_op_en, 1'b0);
    check_cfg("dp_cfg after done", dp_cfg, cfg_m[~c]);
    read_and_check(off_s_pointer, "pointer after done");
    read_and_check(off_s_status, "status after done");
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin : main_seq
    logic c;
    logic g;
    int   it;
    int   k;
    csb_req_valid      = 1'b0;
    csb_req            = '0;
    dp_done            = 1'b0;
    perf_read_stall_d0 = '0;
    perf_read_stall_d1 = '0;
    nvdla_core_rstn    = 1'b0;
    producer_m         = 1'b0;
    consumer_m         = 1'b0;
    op_en_m            = 2'b00;
    cfg_m[0]           = '0;
    cfg_m[1]           = '0;
    stall_m[0]         = '0;
    stall_m[1]         = '0;
    repeat (10) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    @(negedge nvdla_core_clk);
    check_bit("csb_req_ready", csb_req_ready, 1'b1);
    check_bit("csb_resp_valid out of reset", csb_resp_valid, 1'b0);
    check_bit("dp_op_en out of reset", dp_op_en, 1'b0);
    check_bit("slcg_op_en out of reset", slcg_op_en, 1'b0);
    read_and_check(off_s_pointer, "pointer out of reset");

    for (it = 0; it < 10 && timeouts == 0; it++) begin
      c = consumer_m;
      drive_stall();
      for (k = 0; k < 2; k++) begin  // consumed group first
        g = c ^ k[0];
        if (!op_en_m[g]) begin
          program_group(g);
        end
      end
      read_and_check(off_s_pointer, "pointer");
      read_and_check(off_s_status, "status before launch");
      if (!op_en_m[c]) begin
        launch_group(c);
      end else begin
        wait_launch();  // was left pending last layer
      end
      // sometimes queue the other group behind it
      if (!op_en_m[~c] && rand_word() % 32'd2 == 32'd1) begin
        reg_write(1'b1, off_s_pointer, {31'd0, ~c});
        reg_write(rand_word() % 32'd2 == 32'd1, off_d_op_enable, 32'd1);
      end
      read_and_check(off_s_status, "status while running");
      check_cfg("dp_cfg of running group", dp_cfg, cfg_m[c]);
      finish_layer();
    end
    finish_run();
  end

  initial begin : watchdog
    int n;
    for (n = 0; n < 50000; n++) begin
      @(posedge nvdla_core_clk);
    end
    timeouts++;
    $display("simulation still running after 50000 cycles");
    finish_run();
  end

endmodule

`default_nettype wire
